/* Makefile */
# Verilator build and run of the paging core testbench

VERILATOR ?= verilator
TOP       ?= tb_zx_memctl
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test passed
VFLAGS    ?= --timing --assert --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* test/tb_zx_bus_tasks.svh */
`ifndef TB_ZX_BUS_TASKS_SVH
`define TB_ZX_BUS_TASKS_SVH

////////////////////////////////////////////////////////////
// z80 bus cycles, entered and left on a falling edge
////////////////////////////////////////////////////////////

localparam int HOLD_CYC = 4;
localparam int GAP_CYC  = 3;

localparam z_bus_t BUS_IDLE  = '{mreq_n: 1'b1, iorq_n: 1'b1, rd_n: 1'b1, wr_n: 1'b1, m1_n: 1'b1};
localparam z_bus_t BUS_IO_WR = '{mreq_n: 1'b1, iorq_n: 1'b0, rd_n: 1'b1, wr_n: 1'b0, m1_n: 1'b1};
localparam z_bus_t BUS_IO_RD = '{mreq_n: 1'b1, iorq_n: 1'b0, rd_n: 1'b0, wr_n: 1'b1, m1_n: 1'b1};
localparam z_bus_t BUS_FETCH = '{mreq_n: 1'b0, iorq_n: 1'b1, rd_n: 1'b0, wr_n: 1'b1, m1_n: 1'b0};

task automatic idle();
	zbus = BUS_IDLE;
	repeat (GAP_CYC) @(negedge fclk);
endtask

task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
	a    = addr;
	din  = data;
	zbus = BUS_IO_WR;
	repeat (HOLD_CYC) @(negedge fclk);
	idle();
endtask

task automatic mem_fetch(input logic [15:0] addr);
	a    = addr;
	zbus = BUS_FETCH;
	repeat (HOLD_CYC) @(negedge fclk);
	idle();
endtask

// grab dout while dout_en is up, then see it drop after release
task automatic io_read(input logic [15:0] addr, output logic [7:0] data);
	int   cnt;
	logic seen;
	seen = 1'b0;
	data = '0;
	a    = addr;
	zbus = BUS_IO_RD;
	for (cnt = 0; cnt < HOLD_CYC; cnt++)
	begin
		@(negedge fclk);
		if (dout_en && !seen)
		begin
			seen = 1'b1;
			data = dout;
		end
	end
	if (!seen)
		stop_run("timeout: dout_en never went high during the BE read");
	zbus = BUS_IDLE;
	cnt  = 0;
	while (dout_en && cnt < GAP_CYC)
	begin
		@(negedge fclk);
		cnt++;
	end
	if (dout_en)
		stop_run("timeout: dout_en stayed high after the strobes were released");
	repeat (GAP_CYC - cnt) @(negedge fclk);
endtask

////////////////////////////////////////////////////////////
// reference model of the paging registers
////////////////////////////////////////////////////////////

p7ffd_t     ref_p7ffd;
logic       ref_pen;
logic [2:0] ref_border;
logic       ref_dos;
win_map_t   ref_atm [4];

task automatic reset_model();
	ref_p7ffd  = '0;
	ref_pen    = 1'b0;
	ref_border = '0;
	ref_dos    = 1'b1;
	foreach (ref_atm[i])
		ref_atm[i] = '{rom: 1'b1, page: '0};
endtask

// pentagon layout unless the ATM pager is on
function automatic win_map_t expected_window(input logic [1:0] w);
	win_map_t m;
	if (ref_pen)
		m = ref_atm[w];
	else
	begin
		m.rom = (w == 2'd0);
		case (w)
			2'd0:    m.page = {4'd0, ref_p7ffd.rom48, ~ref_dos};
			2'd1:    m.page = 6'd5;
			2'd2:    m.page = 6'd2;
			default: m.page = {3'd0, ref_p7ffd.ram_page};
		endcase
	end
	return m;
endfunction

function automatic logic [7:0] expected_readback(input logic [15:0] addr);
	return {1'b0, expected_window(addr[15:14])};
endfunction

task automatic apply_io_write(input logic [15:0] addr, input logic [7:0] data);
	if (addr[7:0] == `ZX_PORT_7FFD_LO && !addr[15] && !ref_p7ffd.lock)
		ref_p7ffd = p7ffd_t'({2'b00, data[5:0]});
	if (addr[7:0] == `ZX_PORT_FE_LO)
		ref_border = data[2:0];
	if (addr[7:0] == `ZX_PORT_77_LO)
		ref_pen = data[0];
	if (addr[7:0] == `ZX_PORT_F7_LO)
		ref_atm[addr[15:14]] = '{rom: data[6], page: data[5:0]};
endtask

task automatic apply_fetch(input logic [15:0] addr);
	win_map_t m;
	m = expected_window(addr[15:14]);
	if (!m.rom)
		ref_dos = 1'b0;
	else if (addr[15:8] == `ZX_DOS_ENTRY_HI && ref_p7ffd.rom48)
		ref_dos = 1'b1;
endtask

`endif

/* test/tb_zx_memctl.sv */
`timescale 1ns/1ps
`include "zx_params.svh"

module tb_zx_memctl
	import zx_pkg::*;
();

	typedef enum
	{
		OP_CHECK,
		OP_IO_WR,
		OP_IO_RD,
		OP_FETCH
	} op_t;

	logic       fclk;
	logic       arst_n;
	z_bus_t     zbus;
	logic [15:0] a;
	logic [7:0] din;
	mem_sel_t   mem;
	logic [7:0] dout;
	logic       dout_en;
	logic [2:0] border;
	logic       dos;
	integer     seed;

	// stimulus table with one entry per row in each queue
	string      row_name[$];
	op_t        row_op[$];
	logic [15:0] row_addr[$];
	logic [7:0] row_data[$];
	bit         row_rnd[$];
	logic [2:0] row_border[$];
	logic       row_dos[$];

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		assert (act === exp)
		else
			stop_run($sformatf("[FAIL] %s: expected %0h, actual %0h", name, exp, act));
	endtask

	`include "tb_zx_bus_tasks.svh"

	zx_memctl_top i_dut
	(
		.fclk    (fclk   ),
		.arst_n  (arst_n ),
		.zbus    (zbus   ),
		.a       (a      ),
		.din     (din    ),
		.mem     (mem    ),
		.dout    (dout   ),
		.dout_en (dout_en),
		.border  (border ),
		.dos     (dos    )
	);

	initial
	begin
		fclk = 1'b0;
		forever #5 fclk = ~fclk;
	end

	// nothing here should take more than a few microseconds
	initial
	begin
		#200000;
		stop_run("watchdog expired before the stimulus table finished");
	end

	task automatic add_row(input string name, input op_t op, input logic [15:0] addr,
		input logic [7:0] data, input bit rnd, input logic [2:0] exp_border,
		input logic exp_dos);
		row_name.push_back(name);
		row_op.push_back(op);
		row_addr.push_back(addr);
		row_data.push_back(data);
		row_rnd.push_back(rnd);
		row_border.push_back(exp_border);
		row_dos.push_back(exp_dos);
	endtask

	task automatic build_table();
		add_row("reset state",            OP_CHECK, 16'h0000, 8'h00, 1'b0, 3'd0, 1'b1);
		add_row("ram fetch clears dos",   OP_FETCH, 16'h4000, 8'h00, 1'b0, 3'd0, 1'b0);
		add_row("fetch 3dxx no rom48",    OP_FETCH, 16'h3D00, 8'h00, 1'b0, 3'd0, 1'b0);
		add_row("7ffd rom48",             OP_IO_WR, 16'h7FFD, 8'h10, 1'b0, 3'd0, 1'b0);
		add_row("fetch 3dxx enters dos",  OP_FETCH, 16'h3D12, 8'h00, 1'b0, 3'd0, 1'b1);
		add_row("rom fetch keeps dos",    OP_FETCH, 16'h1234, 8'h00, 1'b0, 3'd0, 1'b1);
		add_row("window 3 fetch",         OP_FETCH, 16'hC123, 8'h00, 1'b0, 3'd0, 1'b0);
		add_row("7ffd ram page 3",        OP_IO_WR, 16'h7FFD, 8'h13, 1'b0, 3'd0, 1'b0);
		add_row("fe border 5",            OP_IO_WR, 16'h00FE, 8'h05, 1'b0, 3'd5, 1'b0);
		add_row("7ffd with a15 set",      OP_IO_WR, 16'hFFFD, 8'h07, 1'b0, 3'd5, 1'b0);
		add_row("7ffd sets lock",         OP_IO_WR, 16'h7FFD, 8'h26, 1'b0, 3'd5, 1'b0);
		add_row("7ffd while locked",      OP_IO_WR, 16'h7FFD, 8'h11, 1'b0, 3'd5, 1'b0);
		add_row("fe border 2",            OP_IO_WR, 16'h00FE, 8'hFA, 1'b0, 3'd2, 1'b0);
		add_row("77 pager on",            OP_IO_WR, 16'h0077, 8'h01, 1'b0, 3'd2, 1'b0);
		add_row("f7 window 0",            OP_IO_WR, 16'h00F7, 8'h00, 1'b1, 3'd2, 1'b0);
		add_row("f7 window 1",            OP_IO_WR, 16'h40F7, 8'h00, 1'b1, 3'd2, 1'b0);
		add_row("f7 window 2",            OP_IO_WR, 16'h80F7, 8'h00, 1'b1, 3'd2, 1'b0);
		add_row("f7 window 3",            OP_IO_WR, 16'hC0F7, 8'h00, 1'b1, 3'd2, 1'b0);
		add_row("window 1 fetch",         OP_FETCH, 16'h4321, 8'h00, 1'b0, 3'd2, 1'b0);
		add_row("window 3 fetch paged",   OP_FETCH, 16'hC321, 8'h00, 1'b0, 3'd2, 1'b0);
		add_row("be read window 0",       OP_IO_RD, 16'h00BE, 8'h00, 1'b0, 3'd2, 1'b0);
		add_row("be read window 1",       OP_IO_RD, 16'h40BE, 8'h00, 1'b0, 3'd2, 1'b0);
		add_row("be read window 2",       OP_IO_RD, 16'h80BE, 8'h00, 1'b0, 3'd2, 1'b0);
		add_row("be read window 3",       OP_IO_RD, 16'hC0BE, 8'h00, 1'b0, 3'd2, 1'b0);
	endtask

	// mem is combinational so look 1 ns after the new address
	task automatic sweep_windows(input string name);
		mem_sel_t   exp;
		logic [1:0] w;
		for (int k = 0; k < 4; k++)
		begin
			w = 2'(k);
			a = {w, 14'($random(seed))};
			#1;
			exp = {expected_window(w), a[13:0]};
			check_value($sformatf("%s window %0d", name, k), 32'(exp), 32'(mem));
			@(negedge fclk);
		end
	endtask

	task automatic compare_row(input int idx);
		string name;
		name = row_name[idx];
		check_value({name, " border"}, 32'(row_border[idx]), 32'(border));
		check_value({name, " border model"}, 32'(ref_border), 32'(border));
		check_value({name, " dos"}, 32'(row_dos[idx]), 32'(dos));
		check_value({name, " dout_en idle"}, 32'(0), 32'(dout_en));
		sweep_windows(name);
	endtask

	initial
	begin
		logic [7:0] wdata;
		logic [7:0] rdata;
		seed   = 32'hd736_d47e;
		arst_n = 1'b0;
		zbus   = BUS_IDLE;
		a      = '0;
		din    = '0;
		reset_model();
		build_table();
		repeat (8) @(posedge fclk);
		@(negedge fclk);
		arst_n = 1'b1;
		@(negedge fclk);

		for (int i = 0; i < row_name.size(); i++)
		begin
			wdata = row_data[i];
			if (row_rnd[i])
				wdata = 8'($random(seed));
			case (row_op[i])
				OP_IO_WR:
				begin
					io_write(row_addr[i], wdata);
					apply_io_write(row_addr[i], wdata);
				end
				OP_IO_RD:
				begin
					io_read(row_addr[i], rdata);
					check_value({row_name[i], " dout"}, 32'(expected_readback(row_addr[i])),
						32'(rdata));
				end
				OP_FETCH:
				begin
					apply_fetch(row_addr[i]);
					mem_fetch(row_addr[i]);
				end
				default:
					idle();
			endcase
			compare_row(i);
		end

		$display("Test passed");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+verilog
+incdir+test
verilog/zx_pkg.sv
verilog/zbus_decode.sv
verilog/zports.sv
verilog/atm_pager.sv
verilog/zdos.sv
verilog/zmem_map.sv
verilog/zx_memctl_top.sv
test/tb_zx_memctl.sv

/* verilog/atm_pager.sv */
`timescale 1ns/1ps
`include "zx_params.svh"

module atm_pager
	import zx_pkg::*;
#(
	parameter int win_idx = 0
)
(
	input  logic     fclk,
	input  logic     arst_n,
	input  logic     pg_wr,
	input  win_map_t pg_wdata,
	input  logic     pen,
	input  p7ffd_t   p7ffd,
	input  logic     dos,
	output win_map_t win_map
);

	// fixed pentagon RAM in windows 1 and 2
	localparam logic [`ZX_PAGE_W-1:0] PENT_PAGE_W1 = `ZX_PAGE_W'(5);
	localparam logic [`ZX_PAGE_W-1:0] PENT_PAGE_W2 = `ZX_PAGE_W'(2);

	win_map_t atm_reg;
	win_map_t pent_map;

	// comes up as ROM page 0
	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
			atm_reg <= '{rom: 1'b1, page: '0};
		else if (pg_wr)
			atm_reg <= pg_wdata;
	end

	always_comb
	begin
		case (win_idx)
			0:       pent_map = '{rom: 1'b1,
			                      page: {{(`ZX_PAGE_W-2){1'b0}}, p7ffd.rom48, !dos}};
			1:       pent_map = '{rom: 1'b0, page: PENT_PAGE_W1};
			2:       pent_map = '{rom: 1'b0, page: PENT_PAGE_W2};
			default: pent_map = '{rom: 1'b0, page: {{(`ZX_PAGE_W-3){1'b0}}, p7ffd.ram_page}};
		endcase
	end

	assign win_map = pen ? atm_reg : pent_map;

endmodule

/* verilog/zbus_decode.sv */
`timescale 1ns/1ps
`include "zx_params.svh"

module zbus_decode
	import zx_pkg::*;
(
	input  logic                  fclk,
	input  logic                  arst_n,
	input  z_bus_t                zbus,
	input  logic [`ZX_ADDR_W-1:0] a,
	input  logic [`ZX_DATA_W-1:0] din,
	output logic                  cyc_start,
	output bus_cycle_t            cyc_type,
	output logic [`ZX_ADDR_W-1:0] cyc_addr,
	output logic [`ZX_DATA_W-1:0] cyc_data
);

	dec_state_t state;
	bus_cycle_t cyc_now;
	logic       start_now;

	// what the strobes say right now
	// refresh (mreq alone) and int ack (iorq with m1) give CYC_NONE
	always_comb
	begin
		cyc_now = CYC_NONE;
		if (!zbus.mreq_n && !zbus.rd_n)
			cyc_now = zbus.m1_n ? CYC_MEM_RD : CYC_M1_FETCH;
		else if (!zbus.mreq_n && !zbus.wr_n)
			cyc_now = CYC_MEM_WR;
		else if (!zbus.iorq_n && zbus.m1_n && !zbus.rd_n)
			cyc_now = CYC_IO_RD;
		else if (!zbus.iorq_n && zbus.m1_n && !zbus.wr_n)
			cyc_now = CYC_IO_WR;
	end

	assign start_now = (state == DEC_IDLE) && (cyc_now != CYC_NONE);

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state     <= DEC_IDLE;
			cyc_start <= 1'b0;
			cyc_type  <= CYC_NONE;
		end
		else
		begin
			cyc_start <= start_now;
			if (start_now)
			begin
				state    <= DEC_BUSY;
				cyc_type <= cyc_now;
			end
			// wait for a full release before the next cycle
			else if (state == DEC_BUSY && &zbus)
				state <= DEC_IDLE;
		end
	end

	always_ff @(posedge fclk)
	begin
		if (start_now)
		begin
			cyc_addr <= a;
			cyc_data <= din;
		end
	end

endmodule

/* verilog/zdos.sv */
`timescale 1ns/1ps
`include "zx_params.svh"

module zdos
	import zx_pkg::*;
(
	input  logic                  fclk,
	input  logic                  arst_n,
	input  logic                  cyc_start,
	input  bus_cycle_t            cyc_type,
	input  logic [`ZX_ADDR_W-1:0] cyc_addr,
	input  logic                  fetch_rom,
	input  p7ffd_t                p7ffd,
	output logic                  dos
);

	logic fetch;
	logic entry_hit;

	assign fetch     = cyc_start && (cyc_type == CYC_M1_FETCH);
	assign entry_hit = (cyc_addr[`ZX_ADDR_W-1 -: 8] == `ZX_DOS_ENTRY_HI) && p7ffd.rom48;

	// fetch_rom still valid here, the address is held for the whole cycle
	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
			dos <= 1'b1;
		else if (fetch)
		begin
			if (!fetch_rom)
				dos <= 1'b0;
			else if (entry_hit)
				dos <= 1'b1;
		end
	end

endmodule

/* verilog/zmem_map.sv */
`timescale 1ns/1ps
`include "zx_params.svh"

module zmem_map
	import zx_pkg::*;
(
	input  logic [`ZX_ADDR_W-1:0]    a,
	input  win_map_t [`ZX_WIN_N-1:0] win_maps,
	output mem_sel_t                 mem
);

	localparam int WSEL_W = $clog2(`ZX_WIN_N);

	logic [WSEL_W-1:0] win_sel;
	win_map_t          cur_map;

	// top address bits pick one of the 16k windows
	assign win_sel = a[`ZX_ADDR_W-1 -: WSEL_W];
	assign cur_map = win_maps[win_sel];

	assign mem.rom    = cur_map.rom;
	assign mem.page   = cur_map.page;
	assign mem.offset = a[`ZX_OFS_W-1:0];

endmodule

/* verilog/zports.sv */
`timescale 1ns/1ps
`include "zx_params.svh"

module zports
	import zx_pkg::*;
(
	input  logic                          fclk,
	input  logic                          arst_n,
	input  logic                          cyc_start,
	input  bus_cycle_t                    cyc_type,
	input  logic [`ZX_ADDR_W-1:0]         cyc_addr,
	input  logic [`ZX_DATA_W-1:0]         cyc_data,
	input  z_bus_t                        zbus,
	input  win_map_t [`ZX_WIN_N-1:0]      win_maps,
	output p7ffd_t                        p7ffd,
	output logic                          pen,
	output logic [`ZX_BORDER_W-1:0]       border,
	output logic [`ZX_WIN_N-1:0]          pg_wr,
	output win_map_t                      pg_wdata,
	output logic [`ZX_DATA_W-1:0]         dout,
	output logic                          dout_en
);

	localparam int WSEL_W = $clog2(`ZX_WIN_N);

	logic              io_wr;
	logic              io_rd;
	logic              hit_7ffd;
	logic              hit_fe;
	logic              hit_77;
	logic              hit_f7;
	logic              hit_be;
	logic [WSEL_W-1:0] win_sel;
	win_map_t          rd_map;

	////////////////////////////////////////////////////////////
	// port decode
	////////////////////////////////////////////////////////////

	assign io_wr = cyc_start && (cyc_type == CYC_IO_WR);
	assign io_rd = cyc_start && (cyc_type == CYC_IO_RD);

	assign hit_7ffd = (cyc_addr[7:0] == `ZX_PORT_7FFD_LO) && !cyc_addr[`ZX_ADDR_W-1];
	assign hit_fe   = (cyc_addr[7:0] == `ZX_PORT_FE_LO);
	assign hit_77   = (cyc_addr[7:0] == `ZX_PORT_77_LO);
	assign hit_f7   = (cyc_addr[7:0] == `ZX_PORT_F7_LO);
	assign hit_be   = (cyc_addr[7:0] == `ZX_PORT_BE_LO);

	// window named by the high address bits, as for memory
	assign win_sel = cyc_addr[`ZX_ADDR_W-1 -: WSEL_W];

	////////////////////////////////////////////////////////////
	// pentagon and ATM registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			p7ffd  <= '0;
			pen    <= 1'b0;
			border <= '0;
		end
		else if (io_wr)
		begin
			// lock bit freezes 7FFD until reset
			if (hit_7ffd && !p7ffd.lock)
				p7ffd <= p7ffd_t'({2'b00, cyc_data[5:0]});
			if (hit_fe)
				border <= cyc_data[`ZX_BORDER_W-1:0];
			if (hit_77)
				pen <= cyc_data[0];
		end
	end

	// F7 write goes straight to the selected pager
	always_comb
	begin
		pg_wr = '0;
		if (io_wr && hit_f7)
			pg_wr[win_sel] = 1'b1;
	end

	assign pg_wdata = '{rom: cyc_data[`ZX_PAGE_W], page: cyc_data[`ZX_PAGE_W-1:0]};

	////////////////////////////////////////////////////////////
	// BE readback
	////////////////////////////////////////////////////////////

	assign rd_map = win_maps[win_sel];

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
			dout_en <= 1'b0;
		else if (io_rd && hit_be)
			dout_en <= 1'b1;
		else if (&zbus)
			dout_en <= 1'b0;
	end

	// same layout as the F7 data byte
	always_ff @(posedge fclk)
	begin
		if (io_rd && hit_be)
			dout <= {1'b0, rd_map};
	end

endmodule

/* verilog/zx_memctl_top.sv */
`timescale 1ns/1ps
`include "zx_params.svh"

module zx_memctl_top
	import zx_pkg::*;
(
	input  logic                    fclk,
	input  logic                    arst_n,
	input  z_bus_t                  zbus,
	input  logic [`ZX_ADDR_W-1:0]   a,
	input  logic [`ZX_DATA_W-1:0]   din,
	output mem_sel_t                mem,
	output logic [`ZX_DATA_W-1:0]   dout,
	output logic                    dout_en,
	output logic [`ZX_BORDER_W-1:0] border,
	output logic                    dos
);

	logic                     cyc_start;
	bus_cycle_t               cyc_type;
	logic [`ZX_ADDR_W-1:0]    cyc_addr;
	logic [`ZX_DATA_W-1:0]    cyc_data;
	p7ffd_t                   p7ffd;
	logic                     pen;
	logic [`ZX_WIN_N-1:0]     pg_wr;
	win_map_t                 pg_wdata;
	win_map_t [`ZX_WIN_N-1:0] win_maps;

	////////////////////////////////////////////////////////////
	// bus decode and ports
	////////////////////////////////////////////////////////////

	zbus_decode i_zbus_decode
	(
		.fclk      (fclk     ),
		.arst_n    (arst_n   ),
		.zbus      (zbus     ),
		.a         (a        ),
		.din       (din      ),
		.cyc_start (cyc_start),
		.cyc_type  (cyc_type ),
		.cyc_addr  (cyc_addr ),
		.cyc_data  (cyc_data )
	);

	zports i_zports
	(
		.fclk      (fclk     ),
		.arst_n    (arst_n   ),
		.cyc_start (cyc_start),
		.cyc_type  (cyc_type ),
		.cyc_addr  (cyc_addr ),
		.cyc_data  (cyc_data ),
		.zbus      (zbus     ),
		.win_maps  (win_maps ),
		.p7ffd     (p7ffd    ),
		.pen       (pen      ),
		.border    (border   ),
		.pg_wr     (pg_wr    ),
		.pg_wdata  (pg_wdata ),
		.dout      (dout     ),
		.dout_en   (dout_en  )
	);

	////////////////////////////////////////////////////////////
	// one pager per 16k window
	////////////////////////////////////////////////////////////

	for (genvar gi = 0; gi < `ZX_WIN_N; gi++)
	begin : g_pager
		atm_pager #(.win_idx(gi)) i_atm_pager
		(
			.fclk     (fclk         ),
			.arst_n   (arst_n       ),
			.pg_wr    (pg_wr[gi]    ),
			.pg_wdata (pg_wdata     ),
			.pen      (pen          ),
			.p7ffd    (p7ffd        ),
			.dos      (dos          ),
			.win_map  (win_maps[gi] )
		);
	end

	// dos follows fetches, rom bit straight from the map
	zdos i_zdos
	(
		.fclk      (fclk     ),
		.arst_n    (arst_n   ),
		.cyc_start (cyc_start),
		.cyc_type  (cyc_type ),
		.cyc_addr  (cyc_addr ),
		.fetch_rom (mem.rom  ),
		.p7ffd     (p7ffd    ),
		.dos       (dos      )
	);

	zmem_map i_zmem_map
	(
		.a         (a        ),
		.win_maps  (win_maps ),
		.mem       (mem      )
	);

endmodule

/* verilog/zx_params.svh */
`ifndef ZX_PARAMS_SVH
`define ZX_PARAMS_SVH

// z80 bus widths
`define ZX_ADDR_W 16
`define ZX_DATA_W 8

// ATM paging
`define ZX_PAGE_W 6
`define ZX_WIN_N 4
`define ZX_OFS_W 14

// zx border colour
`define ZX_BORDER_W 3

// i/o port low address bytes
// 7FFD also needs a15 low, Pentagon style
`define ZX_PORT_7FFD_LO 8'hFD
`define ZX_PORT_FE_LO 8'hFE
`define ZX_PORT_77_LO 8'h77
`define ZX_PORT_F7_LO 8'hF7
`define ZX_PORT_BE_LO 8'hBE

// opcode fetch from 3Dxx in 48k ROM enters TR-DOS
`define ZX_DOS_ENTRY_HI 8'h3D

`endif

/* verilog/zx_pkg.sv */
`include "zx_params.svh"

package zx_pkg;

	// classified z80 bus cycle
	typedef enum logic [2:0]
	{
		CYC_NONE,
		CYC_MEM_RD,
		CYC_MEM_WR,
		CYC_M1_FETCH,
		CYC_IO_RD,
		CYC_IO_WR
	} bus_cycle_t;

	typedef enum logic
	{
		DEC_IDLE,
		DEC_BUSY
	} dec_state_t;

	// z80 strobes, all active low
	typedef struct packed
	{
		logic mreq_n;
		logic iorq_n;
		logic rd_n;
		logic wr_n;
		logic m1_n;
	} z_bus_t;

	// mapping of one 16k window
	typedef struct packed
	{
		logic                  rom;
		logic [`ZX_PAGE_W-1:0] page;
	} win_map_t;

	// physical location of a cpu access
	typedef struct packed
	{
		logic                  rom;
		logic [`ZX_PAGE_W-1:0] page;
		logic [`ZX_OFS_W-1:0]  offset;
	} mem_sel_t;

	// bit layout matches the byte written to 7FFD
	typedef struct packed
	{
		logic [1:0] spare;
		logic       lock;
		logic       rom48;
		logic       screen;
		logic [2:0] ram_page;
	} p7ffd_t;

endpackage
